/* Makefile */
VERILATOR ?= verilator
TOP       ?= mbox_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* logic/mbox_bus_pkg.sv */
`default_nettype none

`include "mbox_consts.svh"

package mbox_bus_pkg;

    // byte address on the Wishbone port
    typedef logic [`MBOX_ADR_W-1:0] wb_adr_t;

    // full word, the bus has no byte selects
    typedef logic [`MBOX_DATA_W-1:0] wb_dat_t;

    // one bit per interrupt source
    //   0 rx_not_empty
    //   1 rx_almost_full
    //   2 tx_almost_empty
    //   3 tx_overflow   (sticky)
    //   4 tx_underflow  (sticky)
    //   5 rx_overflow   (sticky)
    //   6 rx_underflow  (sticky)
    typedef logic [`MBOX_IRQ_W-1:0] irq_vec_t;

endpackage

`default_nettype wire

/* logic/mbox_consts.svh */
`ifndef MBOX_CONSTS_SVH
`define MBOX_CONSTS_SVH

// word width on the bus and in both FIFOs
`define MBOX_DATA_W 32

// entries per FIFO, level must be able to hold the full depth
`define MBOX_DEPTH 8
`define MBOX_LVL_W 4

// almost flags: full at level >= AFULL, empty at level <= AEMPTY
`define MBOX_AFULL 6
`define MBOX_AEMPTY 2

// Wishbone byte address space
`define MBOX_ADR_W 5

`define MBOX_REG_TXDATA 5'h00
`define MBOX_REG_RXDATA 5'h04
`define MBOX_REG_STATUS 5'h08
`define MBOX_REG_IRQ_EN 5'h0C
`define MBOX_REG_IRQ_STAT 5'h10

`define MBOX_IRQ_W 7

`endif

/* logic/mbox_fifo_pkg.sv */
`default_nettype none

`include "mbox_consts.svh"

package mbox_fifo_pkg;

    // one stored entry
    typedef logic [`MBOX_DATA_W-1:0] fifo_word_t;

    // occupancy, 0 up to and including the depth
    typedef logic [`MBOX_LVL_W-1:0] fifo_level_t;

endpackage

`default_nettype wire

/* logic/mbox_irq_ctrl.sv */
`default_nettype none

module mbox_irq_ctrl
    import mbox_bus_pkg::*;
(
    input  wire      clk,
    input  wire      rst_n,
    input  wire      rx_empty,
    input  wire      rx_almost_full,
    input  wire      tx_almost_empty,
    input  wire      tx_overflow,
    input  wire      tx_underflow,
    input  wire      rx_overflow,
    input  wire      rx_underflow,
    input  wire      en_wr,
    input  irq_vec_t wdata,
    input  irq_vec_t stat_clr,
    output irq_vec_t irq_en,
    output irq_vec_t irq_stat,
    output logic     irq
);

    // sticky error bits start here in the status vector
    localparam int ERR_LSB = 3;
    localparam int ERR_N   = 4;

    logic [ERR_N-1:0] err_q;
    logic [ERR_N-1:0] err_pulse;
    logic [ERR_N-1:0] err_clr;

    assign err_pulse = {rx_underflow, rx_overflow, tx_underflow, tx_overflow};
    assign err_clr   = stat_clr[ERR_LSB +: ERR_N];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_en <= '0;
        end else if (en_wr) begin
            irq_en <= wdata;
        end
    end

    // write-1-to-clear, a pulse in the same cycle wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= '0;
        end else begin
            err_q <= (err_q & ~err_clr) | err_pulse;
        end
    end

    // level conditions pass straight through and are not clearable
    assign irq_stat = {err_q, tx_almost_empty, rx_almost_full, !rx_empty};

    assign irq = |(irq_stat & irq_en);

endmodule

`default_nettype wire

/* logic/mbox_top.sv */
`default_nettype none

`include "mbox_consts.svh"

module mbox_top
    import mbox_bus_pkg::*;
    import mbox_fifo_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         cyc,
    input  wire         stb,
    input  wire         we,
    input  wb_adr_t     adr,
    input  wb_dat_t     dat_i,
    output wb_dat_t     dat_o,
    output logic        ack,
    output logic        irq,
    input  wire         out_rd,
    output fifo_word_t  out_data,
    output logic        out_empty,
    output fifo_level_t out_level,
    input  wire         in_wr,
    input  fifo_word_t  in_data,
    output logic        in_full,
    output fifo_level_t in_level
);

    logic        tx_wr;
    fifo_word_t  tx_wdata;
    logic        tx_full;
    logic        tx_almost_empty;
    logic        tx_overflow;
    logic        tx_underflow;
    logic        rx_rd;
    fifo_word_t  rx_rdata;
    logic        rx_empty;
    logic        rx_almost_full;
    logic        rx_overflow;
    logic        rx_underflow;
    logic        en_wr;
    irq_vec_t    stat_clr;
    irq_vec_t    irq_en;
    irq_vec_t    irq_stat;

    // host to local
    sync_fifo #(
        .DATA_WIDTH   (`MBOX_DATA_W),
        .DEPTH        (`MBOX_DEPTH),
        .AFULL_LEVEL  (`MBOX_AFULL),
        .AEMPTY_LEVEL (`MBOX_AEMPTY)
    ) tx_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (tx_wr),
        .wr_data      (tx_wdata),
        .rd_en        (out_rd),
        .rd_data      (out_data),
        .level        (out_level),
        .full         (tx_full),
        .empty        (out_empty),
        .almost_full  (),
        .almost_empty (tx_almost_empty),
        .overflow     (tx_overflow),
        .underflow    (tx_underflow)
    );

    // local to host
    sync_fifo #(
        .DATA_WIDTH   (`MBOX_DATA_W),
        .DEPTH        (`MBOX_DEPTH),
        .AFULL_LEVEL  (`MBOX_AFULL),
        .AEMPTY_LEVEL (`MBOX_AEMPTY)
    ) rx_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (in_wr),
        .wr_data      (in_data),
        .rd_en        (rx_rd),
        .rd_data      (rx_rdata),
        .level        (in_level),
        .full         (in_full),
        .empty        (rx_empty),
        .almost_full  (rx_almost_full),
        .almost_empty (),
        .overflow     (rx_overflow),
        .underflow    (rx_underflow)
    );

    mbox_wb_slave u_slave (
        .clk      (clk),
        .rst_n    (rst_n),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_i    (dat_i),
        .dat_o    (dat_o),
        .ack      (ack),
        .tx_wr    (tx_wr),
        .tx_wdata (tx_wdata),
        .rx_rd    (rx_rd),
        .rx_rdata (rx_rdata),
        .tx_level (out_level),
        .rx_level (in_level),
        .tx_full  (tx_full),
        .tx_empty (out_empty),
        .rx_full  (in_full),
        .rx_empty (rx_empty),
        .en_wr    (en_wr),
        .stat_clr (stat_clr),
        .irq_en   (irq_en),
        .irq_stat (irq_stat)
    );

    // enable write data comes straight off the bus, qualified by en_wr
    mbox_irq_ctrl u_irq (
        .clk             (clk),
        .rst_n           (rst_n),
        .rx_empty        (rx_empty),
        .rx_almost_full  (rx_almost_full),
        .tx_almost_empty (tx_almost_empty),
        .tx_overflow     (tx_overflow),
        .tx_underflow    (tx_underflow),
        .rx_overflow     (rx_overflow),
        .rx_underflow    (rx_underflow),
        .en_wr           (en_wr),
        .wdata           (dat_i[`MBOX_IRQ_W-1:0]),
        .stat_clr        (stat_clr),
        .irq_en          (irq_en),
        .irq_stat        (irq_stat),
        .irq             (irq)
    );

endmodule

`default_nettype wire

/* logic/mbox_wb_slave.sv */
`default_nettype none

`include "mbox_consts.svh"

module mbox_wb_slave
    import mbox_bus_pkg::*;
    import mbox_fifo_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         cyc,
    input  wire         stb,
    input  wire         we,
    input  wb_adr_t     adr,
    input  wb_dat_t     dat_i,
    output wb_dat_t     dat_o,
    output logic        ack,
    output logic        tx_wr,
    output fifo_word_t  tx_wdata,
    output logic        rx_rd,
    input  fifo_word_t  rx_rdata,
    input  fifo_level_t tx_level,
    input  fifo_level_t rx_level,
    input  wire         tx_full,
    input  wire         tx_empty,
    input  wire         rx_full,
    input  wire         rx_empty,
    output logic        en_wr,
    output irq_vec_t    stat_clr,
    input  irq_vec_t    irq_en,
    input  irq_vec_t    irq_stat
);

    logic    req;
    logic    wr_req;
    logic    rd_req;
    wb_dat_t status;
    wb_dat_t rd_mux;
    wb_dat_t rd_q;
    logic    rx_sel_q;
    logic    rx_zero_q;

    // new transfer, the cycle that already has ack is not a new one
    assign req    = cyc && stb && !ack;
    assign wr_req = req && we;
    assign rd_req = req && !we;

    // strobes to the FIFOs and the interrupt block, fullness is the FIFO's job
    assign tx_wr    = wr_req && (adr == `MBOX_REG_TXDATA);
    assign tx_wdata = dat_i;
    assign rx_rd    = rd_req && (adr == `MBOX_REG_RXDATA);
    assign en_wr    = wr_req && (adr == `MBOX_REG_IRQ_EN);
    assign stat_clr = (wr_req && (adr == `MBOX_REG_IRQ_STAT)) ?
                      dat_i[`MBOX_IRQ_W-1:0] : '0;

    always_comb begin
        status        = '0;
        status[3:0]   = tx_level;
        status[7:4]   = rx_level;
        status[8]     = tx_full;
        status[9]     = tx_empty;
        status[10]    = rx_full;
        status[11]    = rx_empty;
    end

    // RXDATA is not in here, it is taken from the FIFO during ack
    always_comb begin
        case (adr)
            `MBOX_REG_STATUS:   rd_mux = status;
            `MBOX_REG_IRQ_EN:   rd_mux = wb_dat_t'(irq_en);
            `MBOX_REG_IRQ_STAT: rd_mux = wb_dat_t'(irq_stat);
            default:            rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            rd_q      <= '0;
            rx_sel_q  <= 1'b0;
            rx_zero_q <= 1'b0;
        end else begin
            ack <= req;
            if (req) begin
                rd_q      <= we ? '0 : rd_mux;
                rx_sel_q  <= rx_rd;
                // an empty pop leaves old data on the FIFO port
                rx_zero_q <= rx_empty;
            end else begin
                rx_sel_q  <= 1'b0;
            end
        end
    end

    // popped word is on rx_rdata right after the ack edge
    always_comb begin
        if (rx_sel_q) begin
            dat_o = rx_zero_q ? '0 : wb_dat_t'(rx_rdata);
        end else begin
            dat_o = rd_q;
        end
    end

endmodule

`default_nettype wire

/* logic/sync_fifo.sv */
`default_nettype none

`include "mbox_consts.svh"

module sync_fifo
    import mbox_fifo_pkg::*;
#(
    parameter int DATA_WIDTH   = `MBOX_DATA_W,
    parameter int DEPTH        = `MBOX_DEPTH,
    parameter int AFULL_LEVEL  = `MBOX_AFULL,
    parameter int AEMPTY_LEVEL = `MBOX_AEMPTY
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         wr_en,
    input  fifo_word_t  wr_data,
    input  wire         rd_en,
    output fifo_word_t  rd_data,
    output fifo_level_t level,
    output logic        full,
    output logic        empty,
    output logic        almost_full,
    output logic        almost_empty,
    output logic        overflow,
    output logic        underflow
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      cnt;
    logic                  wr_ok;
    logic                  rd_ok;

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // flags come from the count only
    assign full         = (cnt == CNT_W'(DEPTH));
    assign empty        = (cnt == '0);
    assign almost_full  = (cnt >= CNT_W'(AFULL_LEVEL));
    assign almost_empty = (cnt <= CNT_W'(AEMPTY_LEVEL));
    assign level        = fifo_level_t'(cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            // pointers wrap at the last entry, and only when they advance
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // read word stays until the next accepted read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // one-cycle error pulses for rejected requests
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow  <= wr_en && full;
            underflow <= rd_en && empty;
        end
    end

endmodule

`default_nettype wire

/* verification/mbox_tb.sv */
`default_nettype none

`include "mbox_consts.svh"

module mbox_tb
    import mbox_bus_pkg::*;
    import mbox_fifo_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    // rough cycle budget of each test in test order
    localparam int TEST_CYCLES = 30 + 80 + 100 + 160 + 150 + 250;
    localparam int WATCHDOG_NS = TEST_CYCLES * 2 * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    wb_adr_t     adr;
    wb_dat_t     dat_i;
    wb_dat_t     dat_o;
    logic        ack;
    logic        irq;
    logic        out_rd;
    fifo_word_t  out_data;
    logic        out_empty;
    fifo_level_t out_level;
    logic        in_wr;
    fifo_word_t  in_data;
    logic        in_full;
    fifo_level_t in_level;

    // reference queues and the expected sticky bits
    // sticky bit 0 maps to IRQ_STAT bit 3
    fifo_word_t  tx_q[$];
    fifo_word_t  rx_q[$];
    logic [3:0]  sticky = '0;
    logic [6:0]  en_model = '0;
    logic [31:0] lcg_state = 32'h861d38e9;

    mbox_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_i     (dat_i),
        .dat_o     (dat_o),
        .ack       (ack),
        .irq       (irq),
        .out_rd    (out_rd),
        .out_data  (out_data),
        .out_empty (out_empty),
        .out_level (out_level),
        .in_wr     (in_wr),
        .in_data   (in_data),
        .in_full   (in_full),
        .in_level  (in_level)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] exp_status();
        logic [31:0] s;
        s = '0;
        s[3:0] = 4'(tx_q.size());
        s[7:4] = 4'(rx_q.size());
        s[8]   = (tx_q.size() == `MBOX_DEPTH);
        s[9]   = (tx_q.size() == 0);
        s[10]  = (rx_q.size() == `MBOX_DEPTH);
        s[11]  = (rx_q.size() == 0);
        return s;
    endfunction

    function automatic logic [31:0] exp_irq_stat();
        logic [31:0] s;
        s = '0;
        s[0]   = (rx_q.size() != 0);
        s[1]   = (rx_q.size() >= `MBOX_AFULL);
        s[2]   = (tx_q.size() <= `MBOX_AEMPTY);
        s[6:3] = sticky;
        return s;
    endfunction

    task automatic fail_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic wb_access(input logic wr, input wb_adr_t a, input wb_dat_t wd,
                             output wb_dat_t rd);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_i <= wd;
        @(negedge clk);
        while (!ack) @(negedge clk);
        rd = dat_o;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        // ack is a single-cycle pulse
        @(negedge clk);
        check_value("ack", 32'(ack), 32'(0));
    endtask

    task automatic wb_write(input wb_adr_t a, input wb_dat_t d);
        wb_dat_t unused;
        wb_access(1'b1, a, d, unused);
    endtask

    task automatic wb_read(input wb_adr_t a, output wb_dat_t d);
        wb_access(1'b0, a, '0, d);
    endtask

    task automatic expect_reg(input wb_adr_t a, input logic [31:0] exp, input string name);
        wb_dat_t d;
        wb_read(a, d);
        check_value(name, d, exp);
    endtask

    task automatic local_push(input fifo_word_t d);
        @(posedge clk);
        in_wr   <= 1'b1;
        in_data <= d;
        @(posedge clk);
        in_wr <= 1'b0;
    endtask

    task automatic local_pop(output fifo_word_t d);
        @(posedge clk);
        out_rd <= 1'b1;
        @(posedge clk);
        out_rd <= 1'b0;
        @(negedge clk);
        d = out_data;
    endtask

    task automatic host_push(input wb_dat_t d);
        wb_write(`MBOX_REG_TXDATA, d);
        tx_q.push_back(d);
    endtask

    task automatic host_pop_check();
        expect_reg(`MBOX_REG_RXDATA, rx_q.pop_front(), "dat_o");
    endtask

    task automatic local_pop_check();
        fifo_word_t d;
        local_pop(d);
        check_value("out_data", d, tx_q.pop_front());
    endtask

    task automatic check_levels();
        @(negedge clk);
        check_value("out_level", 32'(out_level), 32'(tx_q.size()));
        check_value("in_level", 32'(in_level), 32'(rx_q.size()));
    endtask

    task automatic check_irq();
        @(negedge clk);
        check_value("irq", 32'(irq), 32'(|(exp_irq_stat() & 32'(en_model))));
    endtask

    task automatic test_reset_state();
        expect_reg(`MBOX_REG_STATUS, exp_status(), "STATUS");
        expect_reg(`MBOX_REG_IRQ_EN, '0, "IRQ_EN");
        expect_reg(`MBOX_REG_IRQ_STAT, exp_irq_stat(), "IRQ_STAT");
        @(negedge clk);
        check_value("irq", 32'(irq), 32'(0));
        check_value("out_empty", 32'(out_empty), 32'(1));
        check_value("in_full", 32'(in_full), 32'(0));
    endtask

    task automatic test_host_to_local();
        for (int i = 0; i < `MBOX_DEPTH; i++) begin
            host_push(next_rand());
            check_levels();
        end
        expect_reg(`MBOX_REG_STATUS, exp_status(), "STATUS");
        while (tx_q.size() > 0) begin
            local_pop_check();
            check_levels();
        end
    endtask

    task automatic test_local_to_host();
        for (int i = 0; i < `MBOX_DEPTH; i++) begin
            rx_q.push_back(next_rand());
            local_push(rx_q[$]);
        end
        expect_reg(`MBOX_REG_STATUS, exp_status(), "STATUS");
        while (rx_q.size() > 0) begin
            host_pop_check();
            expect_reg(`MBOX_REG_STATUS, exp_status(), "STATUS");
        end
    endtask

    task automatic test_errors();
        fifo_word_t junk;
        for (int i = 0; i < `MBOX_DEPTH; i++) begin
            host_push(next_rand());
        end
        // ninth word is dropped by the full outbound FIFO
        wb_write(`MBOX_REG_TXDATA, next_rand());
        sticky[0] = 1'b1;
        check_levels();
        expect_reg(`MBOX_REG_IRQ_STAT, exp_irq_stat(), "IRQ_STAT");
        while (tx_q.size() > 0) begin
            local_pop_check();
        end
        local_pop(junk);
        sticky[1] = 1'b1;
        expect_reg(`MBOX_REG_IRQ_STAT, exp_irq_stat(), "IRQ_STAT");
        expect_reg(`MBOX_REG_RXDATA, '0, "dat_o");
        sticky[3] = 1'b1;
        expect_reg(`MBOX_REG_IRQ_STAT, exp_irq_stat(), "IRQ_STAT");
        for (int i = 0; i < `MBOX_DEPTH; i++) begin
            rx_q.push_back(next_rand());
            local_push(rx_q[$]);
        end
        local_push(next_rand());
        sticky[2] = 1'b1;
        check_levels();
        expect_reg(`MBOX_REG_IRQ_STAT, exp_irq_stat(), "IRQ_STAT");
        while (rx_q.size() > 0) begin
            host_pop_check();
        end
        wb_write(`MBOX_REG_IRQ_STAT, 32'h78);
        sticky = '0;
        expect_reg(`MBOX_REG_IRQ_STAT, exp_irq_stat(), "IRQ_STAT");
    endtask

    task automatic test_irq();
        rx_q.push_back(next_rand());
        local_push(rx_q[$]);
        check_irq();
        wb_write(`MBOX_REG_IRQ_EN, 32'h1);
        en_model = 7'h01;
        expect_reg(`MBOX_REG_IRQ_EN, 32'h1, "IRQ_EN");
        check_irq();
        host_pop_check();
        check_irq();
        // almost full at level 6 and up
        wb_write(`MBOX_REG_IRQ_EN, 32'h2);
        en_model = 7'h02;
        for (int i = 0; i < `MBOX_DEPTH - 1; i++) begin
            rx_q.push_back(next_rand());
            local_push(rx_q[$]);
            check_irq();
        end
        while (rx_q.size() > 0) begin
            host_pop_check();
            check_irq();
        end
        // almost empty at level 2 and below
        wb_write(`MBOX_REG_IRQ_EN, 32'h4);
        en_model = 7'h04;
        for (int i = 0; i < `MBOX_DEPTH; i++) begin
            host_push(next_rand());
            check_irq();
        end
        while (tx_q.size() > 0) begin
            local_pop_check();
            check_irq();
        end
        wb_write(`MBOX_REG_IRQ_EN, 32'h0);
        en_model = '0;
    endtask

    task automatic test_mixed();
        logic [31:0] r;
        for (int i = 0; i < 48; i++) begin
            r = next_rand();
            // pick from the upper bits since the low LCG bits repeat every four draws
            case (r[31:30])
                2'd0: if (tx_q.size() < `MBOX_DEPTH) host_push(next_rand());
                2'd1: if (tx_q.size() > 0) local_pop_check();
                2'd2: if (rx_q.size() < `MBOX_DEPTH) begin
                    rx_q.push_back(next_rand());
                    local_push(rx_q[$]);
                end
                default: if (rx_q.size() > 0) host_pop_check();
            endcase
        end
        expect_reg(`MBOX_REG_STATUS, exp_status(), "STATUS");
        while (tx_q.size() > 0) begin
            local_pop_check();
        end
        while (rx_q.size() > 0) begin
            host_pop_check();
        end
        expect_reg(`MBOX_REG_IRQ_STAT, exp_irq_stat(), "IRQ_STAT");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        fail_run();
    end

    initial begin
        rst_n   = 1'b0;
        cyc     = 1'b0;
        stb     = 1'b0;
        we      = 1'b0;
        adr     = '0;
        dat_i   = '0;
        out_rd  = 1'b0;
        in_wr   = 1'b0;
        in_data = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_host_to_local();
        test_local_to_host();
        test_errors();
        test_irq();
        test_mixed();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/mbox_bus_pkg.sv
logic/mbox_fifo_pkg.sv
logic/sync_fifo.sv
logic/mbox_wb_slave.sv
logic/mbox_irq_ctrl.sv
logic/mbox_top.sv
verification/mbox_tb.sv
